// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/decodePkg.sv
      - hdl/datapathController.sv
      - hdl/registerFile.sv
      - hdl/branchResolver.sv
      - hdl/hazardDetectionUnit.sv
      - hdl/decodeStage.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - testbench/decodeStageTb.sv

// ==== compile.f ====
+incdir+hdl
hdl/decodePkg.sv
hdl/datapathController.sv
hdl/registerFile.sv
hdl/branchResolver.sv
hdl/hazardDetectionUnit.sv
hdl/decodeStage.sv
testbench/decodeStageTb.sv

// ==== hdl/branchResolver.sv ====
`timescale 1ns/10ps
`include "decodeStage_params.svh"

module branchResolver (
    input  decodePkg::instrWord     instruction,
    input  logic [`DATA_WIDTH-1:0]  pc,
    input  decodePkg::branchCtrl    bc,
    input  logic [`DATA_WIDTH-1:0]  rdData1,
    input  logic [`DATA_WIDTH-1:0]  rdData2,
    input  decodePkg::fwdSel        fwdSelA,
    input  decodePkg::fwdSel        fwdSelB,
    input  logic [`DATA_WIDTH-1:0]  fwdFromMem,
    input  logic [`DATA_WIDTH-1:0]  fwdFromWb,
    output logic [`DATA_WIDTH-1:0]  immExt,
    output logic [`DATA_WIDTH-1:0]  branchDest,
    output logic [`DATA_WIDTH-1:0]  jumpDest,
    output logic                    branchTaken
);

    logic [`DATA_WIDTH-1:0] pcPlus4;
    logic [`DATA_WIDTH-1:0] operandB;
    logic [`DATA_WIDTH-1:0] opA;
    logic [`DATA_WIDTH-1:0] opB;
    logic                   cmpResult;

    function automatic logic [`DATA_WIDTH-1:0] pickOperand(
        input decodePkg::fwdSel        sel,
        input logic [`DATA_WIDTH-1:0]  regVal,
        input logic [`DATA_WIDTH-1:0]  memVal,
        input logic [`DATA_WIDTH-1:0]  wbVal
    );
        case (sel)
            decodePkg::regFile: return regVal;
            decodePkg::fromMem: return memVal;
            decodePkg::fromWb:  return wbVal;
            default:            return '0;
        endcase
    endfunction

    //////////////////////////////
    // Operands
    //////////////////////////////
    assign immExt = bc.signExt
                  ? {{(`DATA_WIDTH-16){instruction.iView.imm16[15]}}, instruction.iView.imm16}
                  : {{(`DATA_WIDTH-16){1'b0}}, instruction.iView.imm16};

    // Regimm forms compare against the rt field itself
    assign operandB = bc.useRtImm
                    ? {{(`DATA_WIDTH-`REG_ADDR_WIDTH){1'b0}}, instruction.iView.rt}
                    : rdData2;

    assign opA = pickOperand(fwdSelA, rdData1, fwdFromMem, fwdFromWb);
    assign opB = pickOperand(fwdSelB, operandB, fwdFromMem, fwdFromWb);

    //////////////////////////////
    // Compare and targets
    //////////////////////////////
    always_comb begin
        case (bc.cmpOp)
            decodePkg::cmpEq:  cmpResult = (opA == opB);
            decodePkg::cmpNe:  cmpResult = (opA != opB);
            decodePkg::cmpLez: cmpResult = ($signed(opA) <= 0);
            decodePkg::cmpGtz: cmpResult = ($signed(opA) > 0);
            decodePkg::cmpLtz: cmpResult = ($signed(opA) < 0);
            decodePkg::cmpGez: cmpResult = ($signed(opA) >= 0);
            default:           cmpResult = 1'b0;
        endcase
    end

    assign branchTaken = bc.isBranch & cmpResult;
    assign pcPlus4     = pc + `DATA_WIDTH'd4;
    assign branchDest  = pcPlus4 + (immExt << 2);

    // Register jumps take the forwarded rs value
    assign jumpDest = bc.jumpReg ? opA
                                 : {pcPlus4[`DATA_WIDTH-1:28], instruction.jView.target26, 2'b00};

endmodule

// ==== hdl/datapathController.sv ====
`timescale 1ns/10ps

module datapathController (
    input  decodePkg::instrWord  instruction,
    output decodePkg::exCtrl     ctrl,
    output decodePkg::branchCtrl bc
);

    // ALU operation codes seen by EX
    localparam logic [4:0] aluAdd  = 5'd0;
    localparam logic [4:0] aluSub  = 5'd1;
    localparam logic [4:0] aluAnd  = 5'd2;
    localparam logic [4:0] aluOr   = 5'd3;
    localparam logic [4:0] aluXor  = 5'd4;
    localparam logic [4:0] aluNor  = 5'd5;
    localparam logic [4:0] aluSlt  = 5'd6;
    localparam logic [4:0] aluSltu = 5'd7;
    localparam logic [4:0] aluSll  = 5'd8;
    localparam logic [4:0] aluSrl  = 5'd9;
    localparam logic [4:0] aluSra  = 5'd10;
    localparam logic [4:0] aluSllv = 5'd11;
    localparam logic [4:0] aluSrlv = 5'd12;
    localparam logic [4:0] aluSrav = 5'd13;
    localparam logic [4:0] aluLui  = 5'd14;
    localparam logic [4:0] aluAddu = 5'd15;
    localparam logic [4:0] aluSubu = 5'd16;

    // Destination, write-back source and access size encodings
    localparam logic [1:0] destRt   = 2'd0;
    localparam logic [1:0] destRd   = 2'd1;
    localparam logic [1:0] destRa   = 2'd2;
    localparam logic [1:0] wbAlu    = 2'd0;
    localparam logic [1:0] wbMem    = 2'd1;
    localparam logic [1:0] wbLink   = 2'd2;
    localparam logic [1:0] sizeWord = 2'd0;
    localparam logic [1:0] sizeHalf = 2'd1;
    localparam logic [1:0] sizeByte = 2'd2;

    // Low opcode bits give the width of loads and stores
    function automatic logic [1:0] accessSize(input logic [1:0] opLow);
        case (opLow)
            2'd0:    return sizeByte;
            2'd1:    return sizeHalf;
            default: return sizeWord;
        endcase
    endfunction

    always_comb begin
        ctrl = '{aluOp: aluAdd, regDest: destRt, regWrite: 1'b0, aluSrc: 1'b0,
                 memWrite: 1'b0, memRead: 1'b0, memToReg: wbAlu, byteSel: sizeWord};
        bc   = '{isBranch: 1'b0, isJump: 1'b0, jumpReg: 1'b0, signExt: 1'b0,
                 useRtImm: 1'b0, cmpOp: decodePkg::cmpEq};

        // An all-zero word is a nop and stays inactive
        if (instruction != '0) begin
            case (instruction.rView.opcode)
                6'h00: begin
                    ctrl.regDest  = destRd;
                    ctrl.regWrite = 1'b1;
                    case (instruction.rView.funct)
                        6'h00: ctrl.aluOp = aluSll;
                        6'h02: ctrl.aluOp = aluSrl;
                        6'h03: ctrl.aluOp = aluSra;
                        6'h04: ctrl.aluOp = aluSllv;
                        6'h06: ctrl.aluOp = aluSrlv;
                        6'h07: ctrl.aluOp = aluSrav;
                        6'h20: ctrl.aluOp = aluAdd;
                        6'h21: ctrl.aluOp = aluAddu;
                        6'h22: ctrl.aluOp = aluSub;
                        6'h23: ctrl.aluOp = aluSubu;
                        6'h24: ctrl.aluOp = aluAnd;
                        6'h25: ctrl.aluOp = aluOr;
                        6'h26: ctrl.aluOp = aluXor;
                        6'h27: ctrl.aluOp = aluNor;
                        6'h2A: ctrl.aluOp = aluSlt;
                        6'h2B: ctrl.aluOp = aluSltu;
                        // jr
                        6'h08: begin
                            ctrl.regWrite = 1'b0;
                            bc.isJump     = 1'b1;
                            bc.jumpReg    = 1'b1;
                        end
                        // jalr links into rd
                        6'h09: begin
                            ctrl.memToReg = wbLink;
                            bc.isJump     = 1'b1;
                            bc.jumpReg    = 1'b1;
                        end
                        default: ctrl.regWrite = 1'b0;
                    endcase
                end
                // Regimm, rt picks bltz or bgez
                6'h01: begin
                    bc.isBranch = 1'b1;
                    bc.signExt  = 1'b1;
                    bc.useRtImm = 1'b1;
                    bc.cmpOp    = instruction.iView.rt[0] ? decodePkg::cmpGez
                                                          : decodePkg::cmpLtz;
                end
                6'h02: bc.isJump = 1'b1;
                6'h03: begin
                    ctrl.regDest  = destRa;
                    ctrl.regWrite = 1'b1;
                    ctrl.memToReg = wbLink;
                    bc.isJump     = 1'b1;
                end
                // beq, bne, blez, bgtz
                6'h04, 6'h05, 6'h06, 6'h07: begin
                    bc.isBranch = 1'b1;
                    bc.signExt  = 1'b1;
                    case (instruction.rView.opcode[1:0])
                        2'd0:    bc.cmpOp = decodePkg::cmpEq;
                        2'd1:    bc.cmpOp = decodePkg::cmpNe;
                        2'd2:    bc.cmpOp = decodePkg::cmpLez;
                        default: bc.cmpOp = decodePkg::cmpGtz;
                    endcase
                end
                // Immediate ALU ops, the logical ones zero-extend
                6'h08, 6'h09, 6'h0A, 6'h0B, 6'h0C, 6'h0D, 6'h0E, 6'h0F: begin
                    ctrl.aluSrc   = 1'b1;
                    ctrl.regWrite = 1'b1;
                    bc.signExt    = ~instruction.rView.opcode[2];
                    case (instruction.rView.opcode[2:0])
                        3'd0:    ctrl.aluOp = aluAdd;
                        3'd1:    ctrl.aluOp = aluAddu;
                        3'd2:    ctrl.aluOp = aluSlt;
                        3'd3:    ctrl.aluOp = aluSltu;
                        3'd4:    ctrl.aluOp = aluAnd;
                        3'd5:    ctrl.aluOp = aluOr;
                        3'd6:    ctrl.aluOp = aluXor;
                        default: ctrl.aluOp = aluLui;
                    endcase
                end
                // lb, lh, lw
                6'h20, 6'h21, 6'h23: begin
                    ctrl.aluSrc   = 1'b1;
                    ctrl.regWrite = 1'b1;
                    ctrl.memRead  = 1'b1;
                    ctrl.memToReg = wbMem;
                    ctrl.byteSel  = accessSize(instruction.rView.opcode[1:0]);
                    bc.signExt    = 1'b1;
                end
                // sb, sh, sw
                6'h28, 6'h29, 6'h2B: begin
                    ctrl.aluSrc   = 1'b1;
                    ctrl.memWrite = 1'b1;
                    ctrl.byteSel  = accessSize(instruction.rView.opcode[1:0]);
                    bc.signExt    = 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== hdl/decodePkg.sv ====
`include "decodeStage_params.svh"

package decodePkg;

    //////////////////////////////
    // Instruction formats
    //////////////////////////////
    typedef struct packed {
        logic [5:0]                    opcode;
        logic [`REG_ADDR_WIDTH-1:0]    rs;
        logic [`REG_ADDR_WIDTH-1:0]    rt;
        logic [`REG_ADDR_WIDTH-1:0]    rd;
        logic [4:0]                    shamt;
        logic [5:0]                    funct;
    } rFormat;

    typedef struct packed {
        logic [5:0]                    opcode;
        logic [`REG_ADDR_WIDTH-1:0]    rs;
        logic [`REG_ADDR_WIDTH-1:0]    rt;
        logic [15:0]                   imm16;
    } iFormat;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target26;
    } jFormat;

    // One fetched word, read through whichever format applies
    typedef union packed {
        rFormat rView;
        iFormat iView;
        jFormat jView;
    } instrWord;

    //////////////////////////////
    // Control bundles
    //////////////////////////////
    typedef enum logic [2:0] {
        cmpEq, cmpNe, cmpLez, cmpGtz, cmpLtz, cmpGez
    } cmpOpType;

    // Operand source for the branch comparator
    typedef enum logic [1:0] {
        regFile, fromMem, fromWb, zero
    } fwdSel;

    typedef struct packed {
        logic [4:0] aluOp;
        logic [1:0] regDest;
        logic       regWrite;
        logic       aluSrc;
        logic       memWrite;
        logic       memRead;
        logic [1:0] memToReg;
        logic [1:0] byteSel;
    } exCtrl;

    typedef struct packed {
        logic     isBranch;
        logic     isJump;
        logic     jumpReg;
        logic     signExt;
        logic     useRtImm;
        cmpOpType cmpOp;
    } branchCtrl;

    typedef struct packed {
        logic                       we;
        logic [`REG_ADDR_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0]     data;
    } wbPort;

endpackage

// ==== hdl/decodeStage.sv ====
`timescale 1ns/10ps
`include "decodeStage_params.svh"

module decodeStage (
    input  logic                    Clock,
    input  logic                    rstN,
    input  decodePkg::instrWord     instruction,
    input  decodePkg::instrWord     exInstruction,
    input  logic [`DATA_WIDTH-1:0]  pc,
    input  logic                    exMemRead,
    input  decodePkg::fwdSel        fwdSelA,
    input  decodePkg::fwdSel        fwdSelB,
    input  logic [`DATA_WIDTH-1:0]  fwdFromMem,
    input  logic [`DATA_WIDTH-1:0]  fwdFromWb,
    input  decodePkg::wbPort        wb,
    output decodePkg::exCtrl        ctrl,
    output logic [`DATA_WIDTH-1:0]  readData1,
    output logic [`DATA_WIDTH-1:0]  readData2,
    output logic [`DATA_WIDTH-1:0]  immExt,
    output logic [`DATA_WIDTH-1:0]  branchDest,
    output logic [`DATA_WIDTH-1:0]  jumpDest,
    output logic                    branchTaken,
    output logic                    jump,
    output logic                    pcWriteEnable,
    output logic                    ifidWriteEnable,
    output logic                    ifidFlush,
    output logic                    idexFlush
);

    decodePkg::branchCtrl bc;

    //////////////////////////////
    // Decode and operand read
    //////////////////////////////
    datapathController controller (
        .instruction (instruction),
        .ctrl        (ctrl),
        .bc          (bc)
    );

    registerFile regFile (
        .Clock   (Clock),
        .rstN    (rstN),
        .rdAddr1 (instruction.rView.rs),
        .rdAddr2 (instruction.rView.rt),
        .wb      (wb),
        .rdData1 (readData1),
        .rdData2 (readData2)
    );

    //////////////////////////////
    // Branch resolution and hazards
    //////////////////////////////
    branchResolver resolver (
        .instruction (instruction),
        .pc          (pc),
        .bc          (bc),
        .rdData1     (readData1),
        .rdData2     (readData2),
        .fwdSelA     (fwdSelA),
        .fwdSelB     (fwdSelB),
        .fwdFromMem  (fwdFromMem),
        .fwdFromWb   (fwdFromWb),
        .immExt      (immExt),
        .branchDest  (branchDest),
        .jumpDest    (jumpDest),
        .branchTaken (branchTaken)
    );

    hazardDetectionUnit hazards (
        .instruction     (instruction),
        .exInstruction   (exInstruction),
        .exMemRead       (exMemRead),
        .bc              (bc),
        .branchTaken     (branchTaken),
        .pcWriteEnable   (pcWriteEnable),
        .ifidWriteEnable (ifidWriteEnable),
        .idexFlush       (idexFlush),
        .ifidFlush       (ifidFlush)
    );

    assign jump = bc.isJump;

endmodule

// ==== hdl/decodeStage_params.svh ====
`ifndef DECODESTAGE_PARAMS_SVH
`define DECODESTAGE_PARAMS_SVH

// Datapath and register file sizing
`define DATA_WIDTH     32
`define REG_COUNT      32
`define REG_ADDR_WIDTH 5

`endif

// ==== hdl/hazardDetectionUnit.sv ====
`timescale 1ns/10ps
`include "decodeStage_params.svh"

module hazardDetectionUnit (
    input  decodePkg::instrWord  instruction,
    input  decodePkg::instrWord  exInstruction,
    input  logic                 exMemRead,
    input  decodePkg::branchCtrl bc,
    input  logic                 branchTaken,
    output logic                 pcWriteEnable,
    output logic                 ifidWriteEnable,
    output logic                 idexFlush,
    output logic                 ifidFlush
);

    logic [`REG_ADDR_WIDTH-1:0] exDest;
    logic [`REG_ADDR_WIDTH-1:0] idRs;
    logic [`REG_ADDR_WIDTH-1:0] idRt;
    logic                       exWrites;
    logic                       loadUse;
    logic                       branchDep;
    logic                       stall;

    assign idRs = instruction.rView.rs;
    assign idRt = instruction.rView.rt;

    // Destination of whatever sits in EX
    always_comb begin
        exDest   = exInstruction.iView.rt;
        exWrites = 1'b0;
        case (exInstruction.rView.opcode)
            6'h00: begin
                exDest   = exInstruction.rView.rd;
                exWrites = (exInstruction.rView.funct != 6'h08);
            end
            6'h03: begin
                exDest   = '1;
                exWrites = 1'b1;
            end
            6'h08, 6'h09, 6'h0A, 6'h0B, 6'h0C, 6'h0D, 6'h0E, 6'h0F,
            6'h20, 6'h21, 6'h23: exWrites = 1'b1;
            default: exWrites = 1'b0;
        endcase
    end

    assign loadUse = exMemRead && exInstruction.iView.rt != '0 &&
                     (exInstruction.iView.rt == idRs || exInstruction.iView.rt == idRt);

    // Branch operands resolve here, so an ALU result still in EX is too late
    assign branchDep = (bc.isBranch | bc.jumpReg) && exWrites && exDest != '0 &&
                       (exDest == idRs || (bc.isBranch && !bc.useRtImm && exDest == idRt));

    assign stall           = loadUse | branchDep;
    assign pcWriteEnable   = ~stall;
    assign ifidWriteEnable = ~stall;
    assign idexFlush       = stall;
    assign ifidFlush       = ~stall & (branchTaken | bc.isJump);

endmodule

// ==== hdl/registerFile.sv ====
`timescale 1ns/10ps
`include "decodeStage_params.svh"

module registerFile (
    input  logic                       Clock,
    input  logic                       rstN,
    input  logic [`REG_ADDR_WIDTH-1:0] rdAddr1,
    input  logic [`REG_ADDR_WIDTH-1:0] rdAddr2,
    input  decodePkg::wbPort           wb,
    output logic [`DATA_WIDTH-1:0]     rdData1,
    output logic [`DATA_WIDTH-1:0]     rdData2
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    // Write port, register zero is never written
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && wb.addr != '0) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // No bypass here, same-cycle write data arrives through forwarding
    always_comb begin
        rdData1 = (rdAddr1 == '0) ? '0 : regs[rdAddr1];
        rdData2 = (rdAddr2 == '0) ? '0 : regs[rdAddr2];
    end

endmodule

// ==== testbench/decodeStageTb.sv ====
`timescale 1ns/10ps
`include "decodeStage_params.svh"

module decodeStageTb;

    localparam int halfPeriod = 20;
    localparam int maxLines   = 200;

    logic                   Clock;
    logic                   rstN;
    decodePkg::instrWord    instruction;
    decodePkg::instrWord    exInstruction;
    logic [`DATA_WIDTH-1:0] pc;
    logic                   exMemRead;
    decodePkg::fwdSel       fwdSelA;
    decodePkg::fwdSel       fwdSelB;
    logic [`DATA_WIDTH-1:0] fwdFromMem;
    logic [`DATA_WIDTH-1:0] fwdFromWb;
    decodePkg::wbPort       wb;
    decodePkg::exCtrl       ctrl;
    logic [`DATA_WIDTH-1:0] readData1;
    logic [`DATA_WIDTH-1:0] readData2;
    logic [`DATA_WIDTH-1:0] immExt;
    logic [`DATA_WIDTH-1:0] branchDest;
    logic [`DATA_WIDTH-1:0] jumpDest;
    logic                   branchTaken;
    logic                   jump;
    logic                   pcWriteEnable;
    logic                   ifidWriteEnable;
    logic                   ifidFlush;
    logic                   idexFlush;

    // Expected register contents
    logic [`DATA_WIDTH-1:0] model [`REG_COUNT];
    int                     errorCount;
    int                     testsRun;
    int                     testsFailed;
    bit                     runAborted;

    decodeStage UUT (.*);

    initial begin
        Clock = 1'b0;
        forever #halfPeriod Clock = ~Clock;
    end

    task automatic compareWord(input string testName, input string label,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: %s expected %h, actual %h", testName, label,
                     expected, actual);
            errorCount++;
        end
    endtask

    task automatic reportTest(input string testName, input int errorsBefore);
        testsRun++;
        if (errorCount == errorsBefore) begin
            $display("PASS %s", testName);
        end else begin
            testsFailed++;
            $display("FAIL %s", testName);
        end
    endtask

    // R-type add that only puts addresses on both read ports
    task automatic selectRegisters(input logic [4:0] rs, input logic [4:0] rt);
        instruction = {6'h00, rs, rt, 5'd0, 5'd0, 6'h20};
    endtask

    //////////////////////////////
    // One stimulus line
    //////////////////////////////
    task automatic applyVector(input string line);
        string       testName;
        logic [31:0] instrVal;
        logic [31:0] exVal;
        logic [31:0] pcVal;
        logic [31:0] memRd;
        logic [31:0] selA;
        logic [31:0] selB;
        logic [31:0] memVal;
        logic [31:0] wbVal;
        logic [31:0] mask;
        logic [31:0] expCtrl;
        logic [31:0] expImm;
        logic [31:0] expBDest;
        logic [31:0] expJDest;
        logic [4:0]  expFlags;
        int          count;
        int          errorsBefore;
        count = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %b", testName,
                        instrVal, exVal, pcVal, memRd, selA, selB, memVal, wbVal, mask,
                        expCtrl, expImm, expBDest, expJDest, expFlags);
        if (count != 15) begin
            $display("Stimulus line could not be parsed: %s", line);
            errorCount++;
        end else begin
            errorsBefore = errorCount;
            @(negedge Clock);
            instruction   = instrVal;
            exInstruction = exVal;
            pc            = pcVal;
            exMemRead     = memRd[0];
            fwdSelA       = decodePkg::fwdSel'(selA[1:0]);
            fwdSelB       = decodePkg::fwdSel'(selB[1:0]);
            fwdFromMem    = memVal;
            fwdFromWb     = wbVal;
            #(halfPeriod - 1);
            compareWord(testName, "ctrl", expCtrl, {17'd0, ctrl});
            if (mask[0]) begin
                compareWord(testName, "readData1", model[instrVal[25:21]], readData1);
                compareWord(testName, "readData2", model[instrVal[20:16]], readData2);
            end
            if (mask[1]) compareWord(testName, "immExt", expImm, immExt);
            if (mask[2]) compareWord(testName, "branchDest", expBDest, branchDest);
            if (mask[3]) compareWord(testName, "jumpDest", expJDest, jumpDest);
            compareWord(testName, "branchTaken", expFlags[4], branchTaken);
            compareWord(testName, "jump", expFlags[3], jump);
            compareWord(testName, "pcWriteEnable", expFlags[2], pcWriteEnable);
            compareWord(testName, "ifidWriteEnable", expFlags[2], ifidWriteEnable);
            compareWord(testName, "idexFlush", expFlags[1], idexFlush);
            compareWord(testName, "ifidFlush", expFlags[0], ifidFlush);
            reportTest(testName, errorsBefore);
        end
    endtask

    initial begin
        int      seedValue;
        int      cycles;
        int      errorsBefore;
        int      fd;
        int      lineCount;
        string   line;
        realtime resetStart;
        logic    prevClock;
        seedValue   = $urandom(10);
        errorCount  = 0;
        testsRun    = 0;
        testsFailed = 0;
        runAborted  = 1'b0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            model[i] = '0;
        end
        rstN          = 1'b0;
        instruction   = '0;
        exInstruction = '0;
        pc            = '0;
        exMemRead     = 1'b0;
        fwdSelA       = decodePkg::regFile;
        fwdSelB       = decodePkg::regFile;
        fwdFromMem    = '0;
        fwdFromWb     = '0;
        wb            = '0;

        // Reset held for 8 rising clock edges
        cycles     = 0;
        prevClock  = 1'b0;
        resetStart = $realtime;
        while (cycles < 8 && !runAborted) begin
            #1;
            if (Clock === 1'b1 && prevClock === 1'b0) begin
                cycles++;
            end
            prevClock = Clock;
            if ($realtime - resetStart > 32 * halfPeriod) begin
                $display("Reset did not complete within 16 clock cycles");
                runAborted = 1'b1;
            end
        end

        if (!runAborted) begin
            @(negedge Clock);
            rstN = 1'b1;

            //////////////////////////////
            // Register file
            //////////////////////////////
            errorsBefore = errorCount;
            for (int i = 0; i < `REG_COUNT; i++) begin
                @(negedge Clock);
                selectRegisters(5'(i), 5'(31 - i));
                #(halfPeriod - 1);
                compareWord("resetRead", "readData1", '0, readData1);
                compareWord("resetRead", "readData2", '0, readData2);
            end
            reportTest("resetRead", errorsBefore);

            // Port 1 reads the register being written and sees the old value until the edge
            errorsBefore = errorCount;
            for (int i = 1; i < `REG_COUNT; i++) begin
                @(negedge Clock);
                model[i] = $urandom;
                wb = '{we: 1'b1, addr: 5'(i), data: model[i]};
                selectRegisters(5'(i), 5'(i - 1));
                #(halfPeriod - 1);
                compareWord("preload", "readData1 before edge", '0, readData1);
                compareWord("preload", "readData2 after edge", model[i - 1], readData2);
            end
            @(negedge Clock);
            wb = '0;
            selectRegisters(5'd31, 5'd31);
            #(halfPeriod - 1);
            compareWord("preload", "readData1", model[31], readData1);
            reportTest("preload", errorsBefore);

            errorsBefore = errorCount;
            @(negedge Clock);
            wb = '{we: 1'b1, addr: 5'd0, data: $urandom};
            selectRegisters(5'd0, 5'd0);
            @(negedge Clock);
            wb = '0;
            #(halfPeriod - 1);
            compareWord("zeroWrite", "readData1", '0, readData1);
            reportTest("zeroWrite", errorsBefore);

            errorsBefore = errorCount;
            for (int i = 0; i < `REG_COUNT; i++) begin
                @(negedge Clock);
                selectRegisters(5'(i), 5'(i));
                #(halfPeriod - 1);
                compareWord("readBack", "readData1", model[i], readData1);
                compareWord("readBack", "readData2", model[i], readData2);
            end
            reportTest("readBack", errorsBefore);
        end

        //////////////////////////////
        // Decode vectors
        //////////////////////////////
        fd = $fopen("testbench/decodeStage_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Stimulus file testbench/decodeStage_stimulus.txt could not be opened");
            runAborted = 1'b1;
        end else begin
            lineCount = 0;
            while (!runAborted && !$feof(fd)) begin
                lineCount++;
                if (lineCount > maxLines) begin
                    $display("Stimulus file still not finished after %0d lines", maxLines);
                    runAborted = 1'b1;
                end else if ($fgets(line, fd) != 0 && line.len() > 2 && line[0] != "#") begin
                    applyVector(line);
                end
            end
            $fclose(fd);
        end

        $display("Summary: %0d run, %0d passed, %0d failing, %0d errors", testsRun,
                 testsRun - testsFailed, testsFailed, errorCount);
        if (runAborted || errorCount != 0) begin
            $display("tests failed");
        end else begin
            $display("all tests passed");
        end
        $finish;
    end

endmodule

// ==== testbench/decodeStage_stimulus.txt ====
# name instr exInstr pc exMemRead selA selB fwdMem fwdWb mask ctrl immExt branchDest jumpDest flags
# mask 1 operands 2 immExt 4 branchDest 8 jumpDest, flags taken jump pcWE idexFlush ifidFlush
nop     00000000 00000000 00400000 0 0 0 00000000 00000000 3 0000 00000000 0 0 00100
add     00221820 00000000 00400000 0 0 0 00000000 00000000 1 0180 0 0 0 00100
addi    2128FFFC 00000000 00400000 0 0 0 00000000 00000000 3 00C0 FFFFFFFC 0 0 00100
andi    316A8001 00000000 00400000 0 0 0 00000000 00000000 3 08C0 00008001 0 0 00100
ori     35ACF0F0 00000000 00400000 0 0 0 00000000 00000000 3 0CC0 0000F0F0 0 0 00100
lui     3C0E1234 00000000 00400000 0 0 0 00000000 00000000 3 38C0 00001234 0 0 00100
lw      8E0FFFF8 00000000 00400000 0 0 0 00000000 00000000 3 00D4 FFFFFFF8 0 0 00100
lb      82510003 00000000 00400000 0 0 0 00000000 00000000 3 00D6 00000003 0 0 00100
sh      A6930006 00000000 00400000 0 0 0 00000000 00000000 3 0061 00000006 0 0 00100
beqZero 10000004 00000000 00400000 0 0 0 00000000 00000000 6 0000 00000004 00400014 0 10101
bneNot  1422FFFE 00000000 00400000 0 1 2 00000005 00000005 6 0000 FFFFFFFE 003FFFFC 0 00100
bneTkn  1422FFFE 00000000 00400000 0 1 2 00000005 00000006 6 0000 FFFFFFFE 003FFFFC 0 10101
blez    18600010 00000000 00400000 0 3 0 00000000 00000000 6 0000 00000010 00400044 0 10101
bgtz    1C800008 00000000 00400000 0 1 0 80000000 00000000 6 0000 00000008 00400024 0 00100
bltz    04A00020 00000000 00400000 0 2 0 00000000 FFFFFFFF 6 0000 00000020 00400084 0 10101
bgez    04C1FFFF 00000000 00400000 0 1 0 00000000 00000000 6 0000 FFFFFFFF 00400000 0 10101
j       08100040 00000000 90000010 0 0 0 00000000 00000000 8 0000 0 0 90400100 01101
jal     0C000100 00000000 00400000 0 0 0 00000000 00000000 8 0288 0 0 00000400 01101
jr      03E00008 00000000 00400000 0 1 0 00400ABC 00000000 8 0100 0 0 00400ABC 01101
luRs    00221820 8C810000 00400000 1 0 0 00000000 00000000 1 0180 0 0 0 00010
luRt    00221820 8C820000 00400000 1 0 0 00000000 00000000 1 0180 0 0 0 00010
luMiss  00221820 8C870000 00400000 1 0 0 00000000 00000000 1 0180 0 0 0 00100
luZero  00001820 8C800000 00400000 1 0 0 00000000 00000000 1 0180 0 0 0 00100
brDep   10220004 00A61020 00400000 0 1 1 00000007 00000000 6 0000 00000004 00400014 0 10010
brZero  10220004 00220020 00400000 0 1 1 00000007 00000000 6 0000 00000004 00400014 0 10101
